// ==== Makefile ====
# Verilator build and run of the host control port testbench

VERILATOR ?= verilator
TOP       ?= tb_fhe_ctrl
FLIST     ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN      := $(BUILD_DIR)/V$(TOP)
PASS_MSG := ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# output goes to the terminal and is searched for the pass line
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// ==== axil_slave_fsm.sv ====
`timescale 1ns/100ps

module axil_slave_fsm import fhe_ctrl_pkg::*; (
	input  logic                       clk,
	input  logic                       rstn,
	// write address / data / response
	input  logic [AXIL_ADDR_WIDTH-1:0] awaddr,
	input  logic                       awvalid,
	output logic                       awready,
	input  logic [AXIL_DATA_WIDTH-1:0] wdata,
	input  logic                       wvalid,
	output logic                       wready,
	output logic [1:0]                 bresp,
	output logic                       bvalid,
	input  logic                       bready,
	// read address / data
	input  logic [AXIL_ADDR_WIDTH-1:0] araddr,
	input  logic                       arvalid,
	output logic                       arready,
	output logic [AXIL_DATA_WIDTH-1:0] rdata,
	output logic [1:0]                 rresp,
	output logic                       rvalid,
	input  logic                       rready,
	// register side
	input  logic                       inst_refused,	// same cycle as reg_wr.en
	input  logic [AXIL_DATA_WIDTH-1:0] rd_data,		// comb from the regfile
	output reg_wr_t                    reg_wr,
	output logic [REG_ADDR_WIDTH-1:0]  rd_addr
);

	typedef enum logic [1:0] {
		W_IDLE,
		W_DATA,
		W_RESP
	} wr_state_t;

	typedef enum logic [1:0] {
		R_IDLE,
		R_ADDR,
		R_DATA
	} rd_state_t;

	wr_state_t wr_state;
	rd_state_t rd_state;

	logic [REG_ADDR_WIDTH-1:0]  wr_addr_q;
	logic [AXIL_DATA_WIDTH-1:0] wr_data_q;
	logic [1:0]                 bresp_q;
	logic [REG_ADDR_WIDTH-1:0]  rd_addr_q;
	logic [AXIL_DATA_WIDTH-1:0] rdata_q;
	logic                       wr_req;

	// ------------------------------
	// write channel
	// ------------------------------
	assign wr_req = awvalid && wvalid;	// need both aw and w before starting

	always_ff @(posedge clk) begin
		if (!rstn) begin
			wr_state <= W_IDLE;
			bresp_q  <= 2'b00;
		end else begin
			case (wr_state)
				W_IDLE: if (wr_req) wr_state <= W_DATA;
				W_DATA: begin
					wr_state <= W_RESP;	// always a single cycle
					bresp_q  <= inst_refused ? 2'b10 : 2'b00;	// slverr on full fifo
				end
				W_RESP: if (bready) wr_state <= W_IDLE;	// hold until master takes it
				default: wr_state <= W_IDLE;
			endcase
		end
	end

	// request is stable while valid, so sample it on the idle exit
	always_ff @(posedge clk) begin
		if (wr_state == W_IDLE && wr_req) begin
			wr_addr_q <= awaddr[REG_ADDR_WIDTH-1:0];	// upper bits ignored
			wr_data_q <= wdata;
		end
	end

	assign awready = (wr_state == W_DATA);
	assign wready  = (wr_state == W_DATA);
	assign bvalid  = (wr_state == W_RESP);
	assign bresp   = bresp_q;

	// strobe exactly once per transaction, in W_DATA
	always_comb begin
		reg_wr.en   = (wr_state == W_DATA);
		reg_wr.addr = wr_addr_q;
		reg_wr.data = wr_data_q;
	end

	// ------------------------------
	// read channel
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!rstn) begin
			rd_state <= R_IDLE;
		end else begin
			case (rd_state)
				R_IDLE: if (arvalid) rd_state <= R_ADDR;	// arready a cycle later
				R_ADDR: rd_state <= R_DATA;
				R_DATA: if (rready) rd_state <= R_IDLE;
				default: rd_state <= R_IDLE;
			endcase
		end
	end

	// address held in R_ADDR so the mux settles before rdata is flopped
	always_ff @(posedge clk) begin
		if (rd_state == R_IDLE && arvalid) begin
			rd_addr_q <= araddr[REG_ADDR_WIDTH-1:0];
		end
		if (rd_state == R_ADDR) begin
			rdata_q <= rd_data;	// frozen through R_DATA
		end
	end

	assign arready = (rd_state == R_ADDR);
	assign rvalid  = (rd_state == R_DATA);
	assign rdata   = rdata_q;
	assign rresp   = 2'b00;	// reads never fail, misses return the marker word
	assign rd_addr = rd_addr_q;

endmodule

// ==== cfg_regfile.sv ====
`timescale 1ns/100ps

module cfg_regfile import fhe_ctrl_pkg::*; (
	input  logic                       clk,
	input  logic                       rstn,
	input  reg_wr_t                    reg_wr,
	input  logic [REG_ADDR_WIDTH-1:0]  rd_addr,
	input  fifo_status_t               fifo_status,
	output logic [AXIL_DATA_WIDTH-1:0] rd_data,
	output rlwe_cfg_t                  rlwe_cfg,
	output lwe_cfg_t                   lwe_cfg
);

	rlwe_cfg_t                               rlwe_r;
	logic [LWE_BIT_WIDTH-1:0]                lwe_q_mask_r;	// 511 for q = 512
	logic [3:0]                              embed_factor_r;	// 2N / lwe q, 4 or 8
	logic [NUM_GATES-1:0][LWE_BIT_WIDTH-1:0] bound1_r;

	logic [LWE_BIT_WIDTH:0]   lwe_q;	// one bit wider, mask 1023 gives 1024
	logic [LWE_BIT_WIDTH-1:0] lwe_q_half;

	// ------------------------------
	// register write
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!rstn) begin
			rlwe_r         <= '0;
			lwe_q_mask_r   <= '0;
			embed_factor_r <= '0;
			bound1_r       <= '0;
		end else if (reg_wr.en) begin
			case (reg_wr.addr)
				// 64 bit values come in one half at a time
				ADDR_RLWE_Q:                 rlwe_r.q[31:0]          <= reg_wr.data;
				ADDR_RLWE_Q + 8'h4:          rlwe_r.q[63:32]         <= reg_wr.data;
				ADDR_BARRETT_M:              rlwe_r.barrett_m[31:0]  <= reg_wr.data;
				ADDR_BARRETT_M + 8'h4:       rlwe_r.barrett_m[63:32] <= reg_wr.data;
				// narrow ones keep the low bits
				ADDR_BARRETT_K2:    rlwe_r.k2       <= reg_wr.data[6:0];
				ADDR_RLWE_LEN:      rlwe_r.length   <= reg_wr.data[11:0];
				ADDR_LOG2_RLWE_LEN: rlwe_r.log2_len <= reg_wr.data[3:0];
				ADDR_LWE_Q_MASK:    lwe_q_mask_r    <= reg_wr.data[LWE_BIT_WIDTH-1:0];
				ADDR_EMBED_FACTOR:  embed_factor_r  <= reg_wr.data[3:0];
				default: ;	// inst port and unmapped, nothing stored here
			endcase
			// bound1 block, one word per gate
			for (int g = 0; g < NUM_GATES; g++) begin
				if (reg_wr.addr == ADDR_BOUND1_BASE + 4 * g) begin
					bound1_r[g] <= reg_wr.data[LWE_BIT_WIDTH-1:0];
				end
			end
		end
	end

	// ------------------------------
	// bound2 = (bound1 + q/2) & mask
	// ------------------------------
	assign lwe_q      = {1'b0, lwe_q_mask_r} + 1'b1;
	assign lwe_q_half = lwe_q[LWE_BIT_WIDTH:1];	// q / 2

	always_comb begin
		lwe_cfg.lwe_q_mask   = lwe_q_mask_r;
		lwe_cfg.embed_factor = embed_factor_r;
		lwe_cfg.bound1       = bound1_r;
		for (int g = 0; g < NUM_GATES; g++) begin
			// carry out of bit 9 drops, mask wraps mod q anyway
			lwe_cfg.bound2[g] = (bound1_r[g] + lwe_q_half) & lwe_q_mask_r;
		end
	end

	assign rlwe_cfg = rlwe_r;

	// ------------------------------
	// readback mux
	// ------------------------------
	always_comb begin
		rd_data = READ_MISS_WORD;	// unmapped, also the write-only inst port
		case (rd_addr)
			ADDR_RLWE_Q:           rd_data = rlwe_r.q[31:0];
			ADDR_RLWE_Q + 8'h4:    rd_data = rlwe_r.q[63:32];
			ADDR_BARRETT_M:        rd_data = rlwe_r.barrett_m[31:0];
			ADDR_BARRETT_M + 8'h4: rd_data = rlwe_r.barrett_m[63:32];
			ADDR_BARRETT_K2:       rd_data = {25'b0, rlwe_r.k2};
			ADDR_RLWE_LEN:         rd_data = {20'b0, rlwe_r.length};
			ADDR_LOG2_RLWE_LEN:    rd_data = {28'b0, rlwe_r.log2_len};
			ADDR_LWE_Q_MASK: begin
				rd_data = {{(AXIL_DATA_WIDTH - LWE_BIT_WIDTH){1'b0}}, lwe_q_mask_r};
			end
			ADDR_EMBED_FACTOR:     rd_data = {28'b0, embed_factor_r};
			ADDR_FIFO_STATE:       rd_data = {24'b0, fifo_status};	// empties on top
			default: ;
		endcase
		for (int g = 0; g < NUM_GATES; g++) begin
			if (rd_addr == ADDR_BOUND1_BASE + 4 * g) begin
				rd_data = {{(AXIL_DATA_WIDTH - LWE_BIT_WIDTH){1'b0}}, bound1_r[g]};
			end
		end
	end

endmodule

// ==== fhe_ctrl_chk.sv ====
`timescale 1ns/100ps

module fhe_ctrl_chk import fhe_ctrl_pkg::*; #(
	parameter int INST_ID_WIDTH = 6
) (
	input logic                       clk,
	input logic                       rstn,
	input logic                       awvalid,
	input logic                       awready,
	input logic                       wvalid,
	input logic                       wready,
	input logic [1:0]                 bresp,
	input logic                       bvalid,
	input logic                       bready,
	input logic [AXIL_DATA_WIDTH-1:0] rdata,
	input logic                       rvalid,
	input logic                       rready,
	input fifo_status_t               fifo_status,
	input lwe_cfg_t                   lwe_cfg,
	input logic                       inst_wr_en,
	input logic [INST_ID_WIDTH-1:0]   inst_id
);

	int unsigned fail_cnt = 0;	// read by the testbench at the end

	logic [NUM_GATES-1:0][LWE_BIT_WIDTH-1:0] bound2_exp;

	// half of q is (mask + 1) / 2, sum wraps through the mask
	always_comb begin
		for (int g = 0; g < NUM_GATES; g++) begin
			bound2_exp[g] = LWE_BIT_WIDTH'((int'(lwe_cfg.bound1[g])
				+ (int'(lwe_cfg.lwe_q_mask) + 1) / 2) & int'(lwe_cfg.lwe_q_mask));
		end
	end

	// ------------------------------
	// AXI-lite handshake
	// ------------------------------
	a_b_hold: assert property (@(posedge clk) disable iff (!rstn)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else begin $error("bvalid or bresp changed before bready"); fail_cnt++; end

	a_r_hold: assert property (@(posedge clk) disable iff (!rstn)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else begin $error("rvalid or rdata changed before rready"); fail_cnt++; end

	a_aw_w_pair: assert property (@(posedge clk) disable iff (!rstn) awready == wready)
		else begin $error("awready and wready split"); fail_cnt++; end

	a_aw_once: assert property (@(posedge clk) disable iff (!rstn) awready |=> !awready)
		else begin $error("awready high for more than one cycle"); fail_cnt++; end

	// idle is neither W_DATA (awready) nor W_RESP (bvalid)
	a_b_latency: assert property (@(posedge clk) disable iff (!rstn)
		awvalid && wvalid && !awready && !bvalid |-> ##2 bvalid)
		else begin $error("bvalid not two cycles after the request"); fail_cnt++; end

	// ------------------------------
	// dispatch and bound2
	// ------------------------------
	a_id_step: assert property (@(posedge clk) disable iff (!rstn)
		inst_wr_en |=> inst_id == $past(inst_id) + 1'b1)
		else begin $error("inst_id did not step after a dispatch"); fail_cnt++; end

	a_id_hold: assert property (@(posedge clk) disable iff (!rstn)
		!inst_wr_en |=> $stable(inst_id))
		else begin $error("inst_id moved without a dispatch"); fail_cnt++; end

	a_no_wr_full: assert property (@(posedge clk) disable iff (!rstn)
		fifo_status.rob_full || fifo_status.key_full |-> !inst_wr_en)
		else begin $error("inst_wr_en while a FIFO is full"); fail_cnt++; end

	a_bound2: assert property (@(posedge clk) disable iff (!rstn) lwe_cfg.bound2 == bound2_exp)
		else begin $error("bound2 does not follow bound1 and the mask"); fail_cnt++; end

endmodule

bind fhe_ctrl_top fhe_ctrl_chk #(
	.INST_ID_WIDTH (INST_ID_WIDTH)
) u_chk (
	.clk         (clk),
	.rstn        (rstn),
	.awvalid     (awvalid),
	.awready     (awready),
	.wvalid      (wvalid),
	.wready      (wready),
	.bresp       (bresp),
	.bvalid      (bvalid),
	.bready      (bready),
	.rdata       (rdata),
	.rvalid      (rvalid),
	.rready      (rready),
	.fifo_status (fifo_status),
	.lwe_cfg     (lwe_cfg),
	.inst_wr_en  (inst_wr_en),
	.inst_id     (inst_id)
);

// ==== fhe_ctrl_pkg.sv ====
package fhe_ctrl_pkg;

	// ------------------------------
	// widths
	// ------------------------------
	localparam int AXIL_ADDR_WIDTH = 32;	// full bus address, only low bits decoded
	localparam int AXIL_DATA_WIDTH = 32;
	localparam int REG_ADDR_WIDTH  = 8;	// decoded part of the address
	localparam int LWE_BIT_WIDTH   = 10;
	localparam int KEY_ADDR_WIDTH  = 20;	// key base, RLWE aligned
	localparam int NUM_GATES       = 6;	// or, and, nor, nand, xor, xnor

	// ------------------------------
	// register map, byte addresses
	// ------------------------------
	localparam logic [REG_ADDR_WIDTH-1:0] ADDR_RLWE_Q        = 8'h00;	// +4 high word
	localparam logic [REG_ADDR_WIDTH-1:0] ADDR_BARRETT_M     = 8'h08;	// +4 high word
	localparam logic [REG_ADDR_WIDTH-1:0] ADDR_BARRETT_K2    = 8'h10;
	localparam logic [REG_ADDR_WIDTH-1:0] ADDR_RLWE_LEN      = 8'h14;
	localparam logic [REG_ADDR_WIDTH-1:0] ADDR_LOG2_RLWE_LEN = 8'h18;
	localparam logic [REG_ADDR_WIDTH-1:0] ADDR_LWE_Q_MASK    = 8'h1C;
	localparam logic [REG_ADDR_WIDTH-1:0] ADDR_EMBED_FACTOR  = 8'h20;
	localparam logic [REG_ADDR_WIDTH-1:0] ADDR_BOUND1_BASE   = 8'h24;	// six words, gate order
	localparam logic [REG_ADDR_WIDTH-1:0] ADDR_INST_IN       = 8'h40;	// write only
	localparam logic [REG_ADDR_WIDTH-1:0] ADDR_FIFO_STATE    = 8'h44;	// read only

	localparam logic [AXIL_DATA_WIDTH-1:0] READ_MISS_WORD = 32'hDEAD_BEEF;

	// instruction opcode, bits 31:30 of the instruction word
	typedef enum logic [1:0] {
		op_bootstrap_init = 2'b00,
		op_bootstrap      = 2'b01,
		op_rlwe_subs      = 2'b10,
		op_rlwe_mult_rgsw = 2'b11
	} opcode_t;

	// one strobe per accepted AXI-lite write
	typedef struct packed {
		logic                       en;
		logic [REG_ADDR_WIDTH-1:0]  addr;
		logic [AXIL_DATA_WIDTH-1:0] data;
	} reg_wr_t;

	typedef struct packed {
		logic [63:0] q;		// RLWE modulus
		logic [63:0] barrett_m;	// barrett precompute for q
		logic [6:0]  k2;	// barrett k times 2
		logic [11:0] length;	// RLWE length
		logic [3:0]  log2_len;
	} rlwe_cfg_t;

	// bound arrays indexed by gate, entry 0 is the or gate
	typedef struct packed {
		logic [LWE_BIT_WIDTH-1:0]                lwe_q_mask;	// lwe q minus one
		logic [3:0]                              embed_factor;
		logic [NUM_GATES-1:0][LWE_BIT_WIDTH-1:0] bound1;
		logic [NUM_GATES-1:0][LWE_BIT_WIDTH-1:0] bound2;
	} lwe_cfg_t;

	typedef struct packed {
		logic rob_empty;
		logic key_empty;
		logic in_empty;		// global input RLWE FIFO
		logic out_empty;	// global output RLWE FIFO
		logic rob_full;
		logic key_full;
		logic in_full;
		logic out_full;
	} fifo_status_t;

	typedef struct packed {
		opcode_t                  opcode;
		logic [2:0]               gate;
		logic [LWE_BIT_WIDTH-1:0] init_value;
		logic [3:0]               subs_factor;
	} rob_cmd_t;

	typedef struct packed {
		opcode_t                   opcode;
		logic [KEY_ADDR_WIDTH-1:0] base_addr;
	} key_cmd_t;

endpackage

// ==== fhe_ctrl_top.sv ====
`timescale 1ns/100ps

module fhe_ctrl_top import fhe_ctrl_pkg::*; #(
	parameter int INST_ID_WIDTH = 6
) (
	input  logic                       clk,
	input  logic                       rstn,
	// AXI-lite write side
	input  logic [AXIL_ADDR_WIDTH-1:0] awaddr,
	input  logic                       awvalid,
	output logic                       awready,
	input  logic [AXIL_DATA_WIDTH-1:0] wdata,
	input  logic                       wvalid,
	output logic                       wready,
	output logic [1:0]                 bresp,
	output logic                       bvalid,
	input  logic                       bready,
	// AXI-lite read side
	input  logic [AXIL_ADDR_WIDTH-1:0] araddr,
	input  logic                       arvalid,
	output logic                       arready,
	output logic [AXIL_DATA_WIDTH-1:0] rdata,
	output logic [1:0]                 rresp,
	output logic                       rvalid,
	input  logic                       rready,
	// fifo flags in, config out
	input  fifo_status_t               fifo_status,
	output rlwe_cfg_t                  rlwe_cfg,
	output lwe_cfg_t                   lwe_cfg,
	// instruction dispatch
	output logic                       inst_wr_en,
	output rob_cmd_t                   rob_cmd,
	output key_cmd_t                   key_cmd,
	output logic [INST_ID_WIDTH-1:0]   inst_id
);

	reg_wr_t                    reg_wr;	// fsm to regfile and dispatcher
	logic [REG_ADDR_WIDTH-1:0]  rd_addr;
	logic [AXIL_DATA_WIDTH-1:0] rd_data;
	logic                       inst_refused;

	// ------------------------------
	// AXI-lite slave
	// ------------------------------
	axil_slave_fsm u_fsm (
		.clk          (clk),
		.rstn         (rstn),
		.awaddr       (awaddr),
		.awvalid      (awvalid),
		.awready      (awready),
		.wdata        (wdata),
		.wvalid       (wvalid),
		.wready       (wready),
		.bresp        (bresp),
		.bvalid       (bvalid),
		.bready       (bready),
		.araddr       (araddr),
		.arvalid      (arvalid),
		.arready      (arready),
		.rdata        (rdata),
		.rresp        (rresp),
		.rvalid       (rvalid),
		.rready       (rready),
		.inst_refused (inst_refused),
		.rd_data      (rd_data),
		.reg_wr       (reg_wr),
		.rd_addr      (rd_addr)
	);

	cfg_regfile u_regs (
		.clk         (clk),
		.rstn        (rstn),
		.reg_wr      (reg_wr),
		.rd_addr     (rd_addr),
		.fifo_status (fifo_status),
		.rd_data     (rd_data),
		.rlwe_cfg    (rlwe_cfg),
		.lwe_cfg     (lwe_cfg)
	);

	// only block that looks at the inst port address
	inst_dispatch #(
		.INST_ID_WIDTH (INST_ID_WIDTH)
	) u_dispatch (
		.clk          (clk),
		.rstn         (rstn),
		.reg_wr       (reg_wr),
		.fifo_status  (fifo_status),
		.inst_wr_en   (inst_wr_en),
		.inst_refused (inst_refused),
		.rob_cmd      (rob_cmd),
		.key_cmd      (key_cmd),
		.inst_id      (inst_id)
	);

endmodule

// ==== inst_dispatch.sv ====
`timescale 1ns/100ps

module inst_dispatch import fhe_ctrl_pkg::*; #(
	parameter int INST_ID_WIDTH = 6
) (
	input  logic                     clk,
	input  logic                     rstn,
	input  reg_wr_t                  reg_wr,
	input  fifo_status_t             fifo_status,
	output logic                     inst_wr_en,	// to ROB and key-load fifo
	output logic                     inst_refused,	// back to the AXI side, slverr
	output rob_cmd_t                 rob_cmd,
	output key_cmd_t                 key_cmd,
	output logic [INST_ID_WIDTH-1:0] inst_id
);

	logic    inst_hit;
	logic    fifo_full;
	opcode_t opcode;

	// ------------------------------
	// accept or refuse
	// ------------------------------
	assign inst_hit  = reg_wr.en && (reg_wr.addr == ADDR_INST_IN);
	assign fifo_full = fifo_status.rob_full || fifo_status.key_full;	// both get the inst

	assign inst_wr_en   = inst_hit && !fifo_full;
	assign inst_refused = inst_hit && fifo_full;

	assign opcode = opcode_t'(reg_wr.data[31:30]);

	// ------------------------------
	// field decode
	// ------------------------------
	always_comb begin
		rob_cmd = '0;	// quiet bus between instructions
		key_cmd = '0;
		if (inst_hit) begin
			rob_cmd.opcode      = opcode;
			rob_cmd.gate        = reg_wr.data[29:27];	// bootstrap init only
			rob_cmd.init_value  = reg_wr.data[26:17];
			rob_cmd.subs_factor = reg_wr.data[29:26];	// overlaps gate, rlwe subs only
			key_cmd.opcode      = opcode;
			// init packs gate and init value above a 17 bit key address
			if (opcode == op_bootstrap_init) begin
				key_cmd.base_addr = {3'b0, reg_wr.data[16:0]};
			end else begin
				key_cmd.base_addr = reg_wr.data[KEY_ADDR_WIDTH-1:0];
			end
		end
	end

	// ------------------------------
	// iNTT id, one per accepted inst
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!rstn) begin
			inst_id <= '0;
		end else if (inst_wr_en) begin
			inst_id <= inst_id + 1'b1;	// wraps at the id width
		end
	end

endmodule

// ==== tb_fhe_ctrl.sv ====
`timescale 1ns/100ps

module tb_fhe_ctrl import fhe_ctrl_pkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int ID_W       = 6;
	localparam int NUM_INST   = 68;	// past one id wrap
	// cfg writes and reads, misses, bound sweeps, insts, refusals, fifo reads
	localparam int NUM_TXN    = 15 * 2 + 4 + 3 * 7 + NUM_INST + 3 + 8;

	logic                       clk = 1'b0;
	logic                       rstn;
	logic [AXIL_ADDR_WIDTH-1:0] awaddr, araddr;
	logic [AXIL_DATA_WIDTH-1:0] wdata, rdata;
	logic                       awvalid, awready, wvalid, wready, bvalid, bready;
	logic                       arvalid, arready, rvalid, rready;
	logic [1:0]                 bresp, rresp;
	fifo_status_t               fifo_status;
	rlwe_cfg_t                  rlwe_cfg;
	lwe_cfg_t                   lwe_cfg;
	logic                       inst_wr_en;
	rob_cmd_t                   rob_cmd, seen_rob;
	key_cmd_t                   key_cmd, seen_key;
	logic [ID_W-1:0]            inst_id;

	logic [31:0] lfsr = 32'h828e_6d83;
	logic [31:0] exp_reg [15];	// masked model of 0x00 to 0x38
	int          err_cnt   = 0;
	int          pulse_cnt = 0;

	fhe_ctrl_top #(.INST_ID_WIDTH(ID_W)) uut (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ------------------------------
	// helpers
	// ------------------------------
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];	// taps 32 22 2 1
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [31:0] reg_mask(input logic [7:0] addr);
		case (addr)
			ADDR_BARRETT_K2:                       return 32'h7F;
			ADDR_RLWE_LEN:                         return 32'hFFF;
			ADDR_LOG2_RLWE_LEN, ADDR_EMBED_FACTOR: return 32'hF;
			ADDR_LWE_Q_MASK:                       return 32'h3FF;
			default: return (addr >= ADDR_BOUND1_BASE) ? 32'h3FF : 32'hFFFF_FFFF;	// bound1 or 64 bit halves
		endcase
	endfunction

	function automatic rob_cmd_t rob_expect(input logic [31:0] inst);
		rob_cmd_t c;
		c.opcode      = opcode_t'(inst[31:30]);
		c.gate        = inst[29:27];
		c.init_value  = inst[26:17];
		c.subs_factor = inst[29:26];
		return c;
	endfunction

	function automatic key_cmd_t key_expect(input logic [31:0] inst);
		key_cmd_t c;
		c.opcode    = opcode_t'(inst[31:30]);
		c.base_addr = (inst[31:30] == 2'b00) ? {3'b000, inst[16:0]} : inst[19:0];	// init: 17 bits
		return c;
	endfunction

	task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	// ------------------------------
	// AXI-lite master
	// ------------------------------
	task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		logic [31:0] upper;
		int          hold;
		@(negedge clk);
		upper   = rand_bits(24);	// junk above the decoded byte
		hold    = int'(rand_bits(2));
		awaddr  = {upper[23:0], addr};
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		@(negedge clk);
		while (!awready) @(negedge clk);
		@(negedge clk);	// accepted at the edge just passed
		awvalid = 1'b0;
		wvalid  = 1'b0;
		repeat (hold) @(negedge clk);	// bready back-pressure
		bready = 1'b1;
		while (!bvalid) @(negedge clk);
		resp = bresp;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
		logic [31:0] upper;
		int          hold;
		@(negedge clk);
		upper   = rand_bits(24);
		hold    = int'(rand_bits(2));
		araddr  = {upper[23:0], addr};
		arvalid = 1'b1;
		@(negedge clk);
		while (!arready) @(negedge clk);
		@(negedge clk);
		arvalid = 1'b0;	// now in R_DATA
		repeat (hold) @(negedge clk);
		rready = 1'b1;
		while (!rvalid) @(negedge clk);
		data = rdata;
		check_eq("rresp", rresp, 2'b00);	// reads always okay
		@(negedge clk);
		rready = 1'b0;
	endtask

	// dispatch pulses and the commands that ride on them
	always @(negedge clk) begin
		if (inst_wr_en) begin
			pulse_cnt++;
			seen_rob = rob_cmd;
			seen_key = key_cmd;
		end
	end

	initial begin : watchdog
		#((NUM_TXN * 20 + 50) * CLK_PERIOD);
		$display("timeout: the tests did not finish within the allowed time");
		$display("** FAIL **");
		$finish;
	end

	// ------------------------------
	// tests
	// ------------------------------
	initial begin : stimulus
		logic [1:0]      resp;
		logic [31:0]     rd, data, inst;
		logic [ID_W-1:0] id_before;
		int              pulses_before;
		int unsigned     masks [3] = '{511, 1023, 255};
		rstn = 1'b0;
		{awaddr, araddr, wdata} = '0;
		{awvalid, wvalid, bready, arvalid, rready} = '0;
		fifo_status = '0;
		repeat (5) @(negedge clk);
		rstn = 1'b1;
		if (rlwe_cfg !== '0 || lwe_cfg.bound1 !== '0 || inst_id !== '0) begin
			$display("[ERROR] %0t ns: registers not cleared by reset", $time);
			err_cnt++;
		end
		if ({awready, wready, bvalid, arready, rvalid, inst_wr_en} !== '0) begin
			$display("[ERROR] %0t ns: handshake outputs not low after reset", $time);
			err_cnt++;
		end

		// config write, readback and struct outputs
		for (int i = 0; i < 15; i++) begin
			data       = rand_bits(32);
			exp_reg[i] = data & reg_mask(8'(4 * i));
			axil_write(8'(4 * i), data, resp);
			check_eq("config bresp", resp, 2'b00);
		end
		for (int i = 0; i < 15; i++) begin
			axil_read(8'(4 * i), rd);
			check_eq($sformatf("readback 0x%02h", 4 * i), rd, exp_reg[i]);
		end
		check_eq("rlwe q", rlwe_cfg.q, {exp_reg[1], exp_reg[0]});
		check_eq("barrett m", rlwe_cfg.barrett_m, {exp_reg[3], exp_reg[2]});
		check_eq("k2", rlwe_cfg.k2, exp_reg[4]);
		check_eq("rlwe length", rlwe_cfg.length, exp_reg[5]);
		check_eq("log2 length", rlwe_cfg.log2_len, exp_reg[6]);
		check_eq("lwe q mask", lwe_cfg.lwe_q_mask, exp_reg[7]);
		check_eq("embed factor", lwe_cfg.embed_factor, exp_reg[8]);
		for (int g = 0; g < NUM_GATES; g++) begin
			check_eq($sformatf("bound1[%0d]", g), lwe_cfg.bound1[g], exp_reg[9 + g]);
		end
		foreach (masks[m]) begin	// read misses, inst port too
			axil_read((m == 0) ? ADDR_INST_IN : 8'(8'h3C + 12 * m), rd);
			check_eq("miss word", rd, READ_MISS_WORD);
		end
		axil_read(8'hFC, rd);
		check_eq("miss word", rd, READ_MISS_WORD);

		// bound2 sweep, checked by the bound assertion
		foreach (masks[m]) begin
			axil_write(ADDR_LWE_Q_MASK, masks[m], resp);
			for (int g = 0; g < NUM_GATES; g++) begin
				axil_write(8'(ADDR_BOUND1_BASE + 4 * g), rand_bits(10), resp);
			end
		end

		// dispatch, all four opcodes in turn
		for (int i = 0; i < NUM_INST; i++) begin
			inst          = rand_bits(32);
			inst[31:30]   = 2'(i % 4);
			id_before     = inst_id;
			pulses_before = pulse_cnt;
			axil_write(ADDR_INST_IN, inst, resp);
			check_eq("inst bresp", resp, 2'b00);
			check_eq("inst_wr_en pulses", pulse_cnt - pulses_before, 1);
			check_eq("rob_cmd", seen_rob, rob_expect(inst));
			check_eq("key_cmd", seen_key, key_expect(inst));
			check_eq("inst_id", inst_id, ID_W'(id_before + 1'b1));
		end

		// refusal with rob full, key full, both
		for (int k = 1; k < 4; k++) begin
			data                 = rand_bits(8);
			fifo_status          = data[7:0];
			fifo_status.rob_full = k[0];
			fifo_status.key_full = k[1];
			id_before            = inst_id;
			pulses_before        = pulse_cnt;
			axil_write(ADDR_INST_IN, rand_bits(32), resp);
			check_eq("refused bresp", resp, 2'b10);
			check_eq("refused pulses", pulse_cnt - pulses_before, 0);
			check_eq("refused inst_id", inst_id, id_before);
		end

		// fifo state word
		for (int i = 0; i < 8; i++) begin
			data        = rand_bits(8);
			fifo_status = data[7:0];
			axil_read(ADDR_FIFO_STATE, rd);
			check_eq("fifo state", rd, {24'b0, data[7:0]});
		end
		fifo_status = '0;

		repeat (4) @(negedge clk);
		$display("%0d compare errors, %0d assertion failures", err_cnt, uut.u_chk.fail_cnt);
		if (err_cnt == 0 && uut.u_chk.fail_cnt == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
fhe_ctrl_pkg.sv
axil_slave_fsm.sv
cfg_regfile.sv
inst_dispatch.sv
fhe_ctrl_top.sv
fhe_ctrl_chk.sv
tb_fhe_ctrl.sv
